/* elastic_op_set.f */
design/elastic_pkg.sv
design/join_ctrl.sv
design/int_alu_op.sv
design/oehb_buffer.sv
design/mul_pipe_op.sv
design/antitoken_ctrl.sv
design/select_op.sv
design/elastic_op_set.sv
verif/tb_elastic_op_set.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the elastic_op_set testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module tb_elastic_op_set \
	-f elastic_op_set.f \
	-o sim_tb

# a failing run stops at $fatal, the log decides the verdict
./obj_dir/sim_tb | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verif/tb_elastic_op_set.sv */
/*
 * testbench for the elastic operator set
 * random and directed traffic with back-pressure, results checked against reference models
 */
`timescale 1ns/100ps
`default_nettype none

module tb_elastic_op_set import elastic_pkg::*; ();

	localparam int MUL_STAGES = 4;
	localparam int N_ALU_RAND = 360;
	localparam int N_ALU = 18 * 36 + N_ALU_RAND;
	localparam int N_MUL_RAND = 200;
	localparam int N_MUL_LAT = 40;
	localparam int N_SEL = 60;
	// late select tokens carry a second result, so count two per token
	localparam int TOTAL_TXN = N_ALU + N_MUL_RAND + N_MUL_LAT + 2 * N_SEL;
	localparam int CYCLE_LIMIT = 20 * TOTAL_TXN + 200;
	localparam word_t EDGE_VALS [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
		32'h7fff_ffff, 32'h1, 32'd31};

	logic     clk;
	logic     rst;
	alu_req_t alu_a;
	logic     alu_a_valid;
	logic     alu_a_ready;
	word_t    alu_b;
	logic     alu_b_valid;
	logic     alu_b_ready;
	word_t    alu_res;
	logic     alu_res_valid;
	logic     alu_res_ready;
	word_t    mul_a;
	logic     mul_a_valid;
	logic     mul_a_ready;
	word_t    mul_b;
	logic     mul_b_valid;
	logic     mul_b_ready;
	word_t    mul_res;
	logic     mul_res_valid;
	logic     mul_res_ready;
	word_t    sel_cond;
	logic     sel_cond_valid;
	logic     sel_cond_ready;
	word_t    sel_true;
	logic     sel_true_valid;
	logic     sel_true_ready;
	word_t    sel_false;
	logic     sel_false_valid;
	logic     sel_false_ready;
	word_t    sel_res;
	logic     sel_res_valid;
	logic     sel_res_ready;

	int          seed = 32'h9cda;
	int          cycles = 0;
	logic        backpressure;
	// set only while mul_res_ready is held high
	logic        lat_check;
	word_t       alu_exp [$];
	word_t       mul_exp [$];
	int          mul_sent [$];
	word_t       sel_exp [$];
	word_t       exp_alu;
	word_t       exp_mul;
	word_t       exp_sel;
	int          sent_cycle;
	logic [63:0] prod;

	elastic_op_set #(.MUL_STAGES(MUL_STAGES)) i_elastic_op_set (.*);

	// --------------------
	// clock, timeout, readies
	// --------------------
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				stop_on_error($sformatf("timeout after %0d cycles, a handshake never completed",
					cycles));
			end
		end
	end

	// result readies drop low one cycle in four under back-pressure
	initial begin
		logic [2:0] rdy;
		alu_res_ready = 1'b0;
		mul_res_ready = 1'b0;
		sel_res_ready = 1'b0;
		forever begin
			@(posedge clk);
			// next readies are drawn at the edge and applied 2 ns later
			rdy[0] = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
			rdy[1] = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
			rdy[2] = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
			#2;
			alu_res_ready = rdy[0];
			mul_res_ready = rdy[1];
			sel_res_ready = rdy[2];
		end
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at first error");
	endtask

	// --------------------
	// reference model
	// --------------------
	function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
		logic [SHIFT_BITS-1:0] sh;
		logic [63:0]           ext;
		word_t                 sa;
		word_t                 sb;
		sh = b[SHIFT_BITS-1:0];
		// sign-extend to 64 bits, then a logical shift acts as arithmetic
		ext = {{32{a[31]}}, a} >> sh;
		// flipping the sign bit turns signed order into unsigned order
		sa = a ^ 32'h8000_0000;
		sb = b ^ 32'h8000_0000;
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SHL:  return a << sh;
			ALU_LSHR: return a >> sh;
			ALU_ASHR: return ext[31:0];
			ALU_EQ:   return {31'd0, a == b};
			ALU_NE:   return {31'd0, a != b};
			ALU_UGT:  return {31'd0, a > b};
			ALU_UGE:  return {31'd0, a >= b};
			ALU_ULT:  return {31'd0, a < b};
			ALU_ULE:  return {31'd0, a <= b};
			ALU_SGT:  return {31'd0, sa > sb};
			ALU_SGE:  return {31'd0, sa >= sb};
			ALU_SLT:  return {31'd0, sa < sb};
			ALU_SLE:  return {31'd0, sa <= sb};
			default:  return '0;
		endcase
	endfunction

	// --------------------
	// monitor and compare
	// --------------------
	// sampled at the falling edge, where every handshake signal is settled
	always @(negedge clk) begin
		if (!rst) begin
			// ALU result leaves in the same edge as its operands
			if (alu_a_valid && alu_a_ready && alu_b_valid && alu_b_ready) begin
				alu_exp.push_back(ref_alu(alu_a.op, alu_a.a, alu_b));
			end
			if (alu_res_valid && alu_res_ready) begin
				assert (alu_exp.size() > 0) else stop_on_error("alu_res sent without operands");
				exp_alu = alu_exp.pop_front();
				assert (alu_res == exp_alu) else stop_on_error($sformatf(
					"MISMATCH alu_res: got %h expected %h", alu_res, exp_alu));
			end
			// multiplier expects the low word of the full product
			if (mul_a_valid && mul_a_ready && mul_b_valid && mul_b_ready) begin
				prod = 64'(mul_a) * 64'(mul_b);
				mul_exp.push_back(prod[31:0]);
				mul_sent.push_back(cycles);
			end
			if (lat_check && mul_a_valid) begin
				assert (mul_a_ready) else stop_on_error("multiplier stalled with result ready high");
			end
			if (mul_res_valid && mul_res_ready) begin
				assert (mul_exp.size() > 0) else stop_on_error("mul_res sent with nothing in flight");
				exp_mul = mul_exp.pop_front();
				sent_cycle = mul_sent.pop_front();
				assert (mul_res == exp_mul) else stop_on_error($sformatf(
					"MISMATCH mul_res: got %h expected %h", mul_res, exp_mul));
				if (lat_check) begin
					assert (cycles - sent_cycle == MUL_STAGES) else stop_on_error($sformatf(
						"mul_res came %0d cycles after its operands, expected %0d",
						cycles - sent_cycle, MUL_STAGES));
				end
			end
			// a select token moves when the condition and its chosen operand transfer together
			if (sel_cond_valid && sel_cond_ready) begin
				if (sel_cond[0] && sel_true_valid && sel_true_ready) begin
					sel_exp.push_back(sel_true);
				end else if (!sel_cond[0] && sel_false_valid && sel_false_ready) begin
					sel_exp.push_back(sel_false);
				end
			end
			if (sel_res_valid && sel_res_ready) begin
				assert (sel_exp.size() > 0)
					else stop_on_error("sel_res sent without its chosen operand");
				exp_sel = sel_exp.pop_front();
				assert (sel_res == exp_sel) else stop_on_error($sformatf(
					"MISMATCH sel_res: got %h expected %h", sel_res, exp_sel));
			end
		end
	end

	// --------------------
	// drivers
	// --------------------
	task automatic send_alu(input alu_op_t op, input word_t a, input word_t b);
		alu_a.op = op;
		alu_a.a = a;
		alu_b = b;
		alu_a_valid = 1'b1;
		alu_b_valid = 1'b1;
		@(negedge clk);
		while (!(alu_a_ready && alu_b_ready)) @(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic send_mul(input word_t a, input word_t b);
		mul_a = a;
		mul_b = b;
		mul_a_valid = 1'b1;
		mul_b_valid = 1'b1;
		@(negedge clk);
		while (!(mul_a_ready && mul_b_ready)) @(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic drain_mul();
		while (mul_exp.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// chosen lane from cond bit 0, unchosen lane may be absent
	task automatic place_operands(input logic cond_bit, input word_t ch, input word_t un,
			input logic un_v);
		if (cond_bit) begin
			sel_true = ch;
			sel_true_valid = 1'b1;
			sel_false = un;
			sel_false_valid = un_v;
		end else begin
			sel_false = ch;
			sel_false_valid = 1'b1;
			sel_true = un;
			sel_true_valid = un_v;
		end
	endtask

	function automatic logic unchosen_ready(input logic cond_bit);
		return cond_bit ? sel_false_ready : sel_true_ready;
	endfunction

	task automatic wait_select_fire();
		@(negedge clk);
		while (!(sel_res_valid && sel_res_ready)) @(negedge clk);
	endtask

	// with late above 0 the unchosen operand shows up late cycles after the result
	// and a second token waits behind the antitoken meanwhile
	task automatic run_select(input word_t c, input word_t ch1, input word_t un1,
			input word_t ch2, input word_t un2, input int late);
		sel_cond = c;
		sel_cond_valid = 1'b1;
		place_operands(c[0], ch1, un1, late == 0);
		wait_select_fire();
		assert (late > 0 || unchosen_ready(c[0]))
			else stop_on_error("unchosen select operand not taken with the result");
		@(posedge clk);
		#2;
		if (late > 0) begin
			place_operands(c[0], ch2, un1, 1'b0);
			repeat (late) begin
				@(negedge clk);
				assert (!sel_res_valid)
					else stop_on_error("sel_res_valid high while an antitoken is pending");
				@(posedge clk);
				#2;
			end
			// late operand arrives and must vanish without a result
			place_operands(c[0], ch2, un1, 1'b1);
			@(negedge clk);
			assert (unchosen_ready(c[0]) && !sel_res_valid)
				else stop_on_error("late select operand not drained cleanly");
			@(posedge clk);
			#2;
			place_operands(c[0], ch2, un2, 1'b1);
			wait_select_fire();
			assert (unchosen_ready(c[0]))
				else stop_on_error("unchosen select operand not taken with the result");
			@(posedge clk);
			#2;
		end
		sel_cond_valid = 1'b0;
		sel_true_valid = 1'b0;
		sel_false_valid = 1'b0;
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		int late;
		alu_a = '0;
		alu_a_valid = 1'b0;
		alu_b = '0;
		alu_b_valid = 1'b0;
		mul_a = '0;
		mul_a_valid = 1'b0;
		mul_b = '0;
		mul_b_valid = 1'b0;
		sel_cond = '0;
		sel_cond_valid = 1'b0;
		sel_true = '0;
		sel_true_valid = 1'b0;
		sel_false = '0;
		sel_false_valid = 1'b0;
		backpressure = 1'b1;
		lat_check = 1'b0;
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		// idle outputs after reset
		@(negedge clk);
		assert (!alu_res_valid && !mul_res_valid && !sel_res_valid)
			else stop_on_error("a result valid is high after reset with idle inputs");
		@(posedge clk);
		#2;

		// every opcode over all edge value pairs, then random operands
		for (int k = 0; k < 18; k++) begin
			for (int i = 0; i < 6; i++) begin
				for (int j = 0; j < 6; j++) begin
					send_alu(alu_op_t'(k), EDGE_VALS[i], EDGE_VALS[j]);
				end
			end
		end
		for (int n = 0; n < N_ALU_RAND; n++) begin
			send_alu(alu_op_t'(n % 18), $random(seed), $random(seed));
		end
		alu_a_valid = 1'b0;
		alu_b_valid = 1'b0;

		// multiplier under random back-pressure
		for (int n = 0; n < N_MUL_RAND; n++) begin
			send_mul($random(seed), $random(seed));
		end
		mul_a_valid = 1'b0;
		mul_b_valid = 1'b0;
		backpressure = 1'b0;
		@(posedge clk);
		#2;
		drain_mul();

		// back-to-back with exact latency
		lat_check = 1'b1;
		for (int n = 0; n < N_MUL_LAT; n++) begin
			send_mul($random(seed), $random(seed));
		end
		mul_a_valid = 1'b0;
		mul_b_valid = 1'b0;
		drain_mul();
		lat_check = 1'b0;
		backpressure = 1'b1;

		// every third select token gets a late unchosen operand
		for (int n = 0; n < N_SEL; n++) begin
			late = (n % 3 == 2) ? 1 + ($random(seed) & 3) : 0;
			run_select($random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed), late);
		end
		repeat (4) @(posedge clk);

		if (alu_exp.size() == 0 && mul_exp.size() == 0 && sel_exp.size() == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_on_error($sformatf("results missing at end: alu %0d, mul %0d, sel %0d",
				alu_exp.size(), mul_exp.size(), sel_exp.size()));
		end
	end

endmodule

`default_nettype wire

/* design/elastic_op_set.sv */
/*
 * elastic operator set
 * ALU, pipelined multiplier and select side by side on valid/ready channels
 */
`timescale 1ns/100ps
`default_nettype none

module elastic_op_set import elastic_pkg::*; #(
	parameter int MUL_STAGES = 4
) (
	input  wire           clk,
	input  wire           rst,
	// ALU channels
	input  wire alu_req_t alu_a,
	input  wire           alu_a_valid,
	output logic          alu_a_ready,
	input  wire word_t    alu_b,
	input  wire           alu_b_valid,
	output logic          alu_b_ready,
	output word_t         alu_res,
	output logic          alu_res_valid,
	input  wire           alu_res_ready,
	// multiplier channels
	input  wire word_t    mul_a,
	input  wire           mul_a_valid,
	output logic          mul_a_ready,
	input  wire word_t    mul_b,
	input  wire           mul_b_valid,
	output logic          mul_b_ready,
	output word_t         mul_res,
	output logic          mul_res_valid,
	input  wire           mul_res_ready,
	// select channels
	input  wire word_t    sel_cond,
	input  wire           sel_cond_valid,
	output logic          sel_cond_ready,
	input  wire word_t    sel_true,
	input  wire           sel_true_valid,
	output logic          sel_true_ready,
	input  wire word_t    sel_false,
	input  wire           sel_false_valid,
	output logic          sel_false_ready,
	output word_t         sel_res,
	output logic          sel_res_valid,
	input  wire           sel_res_ready
);

	// --------------------
	// operators
	// --------------------
	// purely combinational, no clock
	int_alu_op i_alu (
		.alu_a        (alu_a),
		.alu_a_valid  (alu_a_valid),
		.alu_a_ready  (alu_a_ready),
		.alu_b        (alu_b),
		.alu_b_valid  (alu_b_valid),
		.alu_b_ready  (alu_b_ready),
		.alu_res      (alu_res),
		.alu_res_valid(alu_res_valid),
		.alu_res_ready(alu_res_ready)
	);

	mul_pipe_op #(.MUL_STAGES(MUL_STAGES)) i_mul (
		.clk          (clk),
		.rst          (rst),
		.mul_a        (mul_a),
		.mul_a_valid  (mul_a_valid),
		.mul_a_ready  (mul_a_ready),
		.mul_b        (mul_b),
		.mul_b_valid  (mul_b_valid),
		.mul_b_ready  (mul_b_ready),
		.mul_res      (mul_res),
		.mul_res_valid(mul_res_valid),
		.mul_res_ready(mul_res_ready)
	);

	select_op i_sel (
		.clk            (clk),
		.rst            (rst),
		.sel_cond       (sel_cond),
		.sel_cond_valid (sel_cond_valid),
		.sel_cond_ready (sel_cond_ready),
		.sel_true       (sel_true),
		.sel_true_valid (sel_true_valid),
		.sel_true_ready (sel_true_ready),
		.sel_false      (sel_false),
		.sel_false_valid(sel_false_valid),
		.sel_false_ready(sel_false_ready),
		.sel_res        (sel_res),
		.sel_res_valid  (sel_res_valid),
		.sel_res_ready  (sel_res_ready)
	);

endmodule

`default_nettype wire

/* design/select_op.sv */
/*
 * select operator
 * forwards the operand chosen by cond bit 0, drops the other via antitokens
 */
`timescale 1ns/100ps
`default_nettype none

module select_op import elastic_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire word_t sel_cond,
	input  wire        sel_cond_valid,
	output logic       sel_cond_ready,
	input  wire word_t sel_true,
	input  wire        sel_true_valid,
	output logic       sel_true_ready,
	input  wire word_t sel_false,
	input  wire        sel_false_valid,
	output logic       sel_false_ready,
	output word_t      sel_res,
	output logic       sel_res_valid,
	input  wire        sel_res_ready
);

	logic cond;
	logic chosen_valid;
	logic fire;
	logic gen_true;
	logic gen_false;
	logic kill_true;
	logic kill_false;
	logic anti_stop;

	// only bit 0 of the condition word matters
	assign cond = sel_cond[0];
	assign chosen_valid = cond ? sel_true_valid : sel_false_valid;

	// --------------------
	// firing
	// --------------------
	// unchosen operand is not needed to fire
	assign sel_res_valid = sel_cond_valid & chosen_valid & ~anti_stop;
	assign fire = sel_res_valid & sel_res_ready;
	assign sel_res = cond ? sel_true : sel_false;

	// unchosen operand missing at firing leaves an antitoken behind
	assign gen_true  = fire & ~cond & ~sel_true_valid;
	assign gen_false = fire & cond & ~sel_false_valid;

	// --------------------
	// input readies
	// --------------------
	// kill drains a late operand without producing a result
	assign sel_cond_ready  = ~sel_cond_valid | fire;
	assign sel_true_ready  = ~sel_true_valid | fire | kill_true;
	assign sel_false_ready = ~sel_false_valid | fire | kill_false;

	antitoken_ctrl i_antitoken (
		.clk        (clk),
		.rst        (rst),
		.valid_true (sel_true_valid),
		.valid_false(sel_false_valid),
		.gen_true   (gen_true),
		.gen_false  (gen_false),
		.kill_true  (kill_true),
		.kill_false (kill_false),
		.stop_valid (anti_stop)
	);

endmodule

`default_nettype wire

/* design/antitoken_ctrl.sv */
/*
 * antitoken store for two operand lanes
 * remembers a discarded operand that has not arrived yet and kills it later
 */
`timescale 1ns/100ps
`default_nettype none

module antitoken_ctrl (
	input  wire  clk,
	input  wire  rst,
	input  wire  valid_true,
	input  wire  valid_false,
	input  wire  gen_true,
	input  wire  gen_false,
	output logic kill_true,
	output logic kill_false,
	output logic stop_valid
);

	// lane 0 true operand, lane 1 false operand
	logic [1:0] gen;
	logic [1:0] vld;
	logic [1:0] flag_q;
	logic [1:0] flag_d;

	assign gen = {gen_false, gen_true};
	assign vld = {valid_false, valid_true};

	// set on generate with operand missing, cleared once it shows up
	assign flag_d = ~vld & (gen | flag_q);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flag_q <= '0;
		end else begin
			flag_q <= flag_d;
		end
	end

	// kill now or while pending
	assign kill_true  = gen_true | flag_q[0];
	assign kill_false = gen_false | flag_q[1];
	// no new result while any antitoken waits
	assign stop_valid = |flag_q;

endmodule

`default_nettype wire

/* design/mul_pipe_op.sv */
/*
 * pipelined multiplier operator
 * stall-able product pipeline with a matching valid line and output slot
 */
`timescale 1ns/100ps
`default_nettype none

module mul_pipe_op import elastic_pkg::*; #(
	parameter int MUL_STAGES = 4
) (
	input  wire        clk,
	input  wire        rst,
	input  wire word_t mul_a,
	input  wire        mul_a_valid,
	output logic       mul_a_ready,
	input  wire word_t mul_b,
	input  wire        mul_b_valid,
	output logic       mul_b_ready,
	output word_t      mul_res,
	output logic       mul_res_valid,
	input  wire        mul_res_ready
);

	// output slot supplies the last cycle of latency
	localparam int DEPTH = MUL_STAGES - 1;

	logic             join_valid;
	// whole pipe advances only when the output slot can take
	logic             pipe_en;
	logic [DEPTH-1:0] vld_q;
	word_t            prod_q [DEPTH];

	join_ctrl #(.N(2)) i_join (
		.valid_in ({mul_b_valid, mul_a_valid}),
		.ready_in ({mul_b_ready, mul_a_ready}),
		.valid_out(join_valid),
		.ready_out(pipe_en)
	);

	// --------------------
	// valid delay line
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_q <= '0;
		end else if (pipe_en) begin
			vld_q[0] <= join_valid;
			for (int i = 1; i < DEPTH; i++) begin
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	// --------------------
	// product pipeline
	// --------------------
	// low word of a*b taken at stage 0, later stages carry it along
	// so retiming can spread the multiplier across them
	always_ff @(posedge clk) begin
		if (pipe_en) begin
			prod_q[0] <= mul_a * mul_b;
			for (int i = 1; i < DEPTH; i++) begin
				prod_q[i] <= prod_q[i-1];
			end
		end
	end

	// last stage into the registered output slot
	oehb_buffer i_oehb (
		.clk      (clk),
		.rst      (rst),
		.valid_in (vld_q[DEPTH-1]),
		.ready_in (pipe_en),
		.data_in  (prod_q[DEPTH-1]),
		.valid_out(mul_res_valid),
		.ready_out(mul_res_ready),
		.data_out (mul_res)
	);

endmodule

`default_nettype wire

/* design/oehb_buffer.sv */
/*
 * opaque elastic half buffer
 * one registered slot that cuts the valid and data path
 */
`timescale 1ns/100ps
`default_nettype none

module oehb_buffer import elastic_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        valid_in,
	output logic       ready_in,
	input  wire word_t data_in,
	output logic       valid_out,
	input  wire        ready_out,
	output word_t      data_out
);

	// free when empty or when the held word leaves this cycle
	assign ready_in = ~valid_out | ready_out;

	// --------------------
	// slot state
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_out <= 1'b0;
		end else if (ready_in) begin
			valid_out <= valid_in;
		end
	end

	// payload only loads on a real transfer
	always_ff @(posedge clk) begin
		if (ready_in && valid_in) begin
			data_out <= data_in;
		end
	end

endmodule

`default_nettype wire

/* design/int_alu_op.sv */
/*
 * integer ALU operator
 * joins opcode+a with b and gives the result in the same cycle
 */
`timescale 1ns/100ps
`default_nettype none

module int_alu_op import elastic_pkg::*; (
	input  wire alu_req_t alu_a,
	input  wire           alu_a_valid,
	output logic          alu_a_ready,
	input  wire word_t    alu_b,
	input  wire           alu_b_valid,
	output logic          alu_b_ready,
	output word_t         alu_res,
	output logic          alu_res_valid,
	input  wire           alu_res_ready
);

	logic [SHIFT_BITS-1:0] shamt;

	// both operands move in the same cycle
	join_ctrl #(.N(2)) i_join (
		.valid_in ({alu_b_valid, alu_a_valid}),
		.ready_in ({alu_b_ready, alu_a_ready}),
		.valid_out(alu_res_valid),
		.ready_out(alu_res_ready)
	);

	// only the low bits of b shift
	assign shamt = alu_b[SHIFT_BITS-1:0];

	// --------------------
	// datapath
	// --------------------
	always_comb begin
		case (alu_a.op)
			ALU_ADD:  alu_res = alu_a.a + alu_b;
			// a minus b
			ALU_SUB:  alu_res = alu_a.a - alu_b;
			ALU_AND:  alu_res = alu_a.a & alu_b;
			ALU_OR:   alu_res = alu_a.a | alu_b;
			ALU_XOR:  alu_res = alu_a.a ^ alu_b;
			ALU_SHL:  alu_res = alu_a.a << shamt;
			ALU_LSHR: alu_res = alu_a.a >> shamt;
			// sign bit fills from the left
			ALU_ASHR: alu_res = word_t'($signed(alu_a.a) >>> shamt);
			// unsigned compares
			ALU_EQ:   alu_res = word_t'(alu_a.a == alu_b);
			ALU_NE:   alu_res = word_t'(alu_a.a != alu_b);
			ALU_UGT:  alu_res = word_t'(alu_a.a > alu_b);
			ALU_UGE:  alu_res = word_t'(alu_a.a >= alu_b);
			ALU_ULT:  alu_res = word_t'(alu_a.a < alu_b);
			ALU_ULE:  alu_res = word_t'(alu_a.a <= alu_b);
			// two's complement compares
			ALU_SGT:  alu_res = word_t'($signed(alu_a.a) > $signed(alu_b));
			ALU_SGE:  alu_res = word_t'($signed(alu_a.a) >= $signed(alu_b));
			ALU_SLT:  alu_res = word_t'($signed(alu_a.a) < $signed(alu_b));
			ALU_SLE:  alu_res = word_t'($signed(alu_a.a) <= $signed(alu_b));
			// unused encodings
			default:  alu_res = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/join_ctrl.sv */
/*
 * valid/ready join
 * fires when every input holds a token, all inputs transfer together
 */
`timescale 1ns/100ps
`default_nettype none

module join_ctrl #(
	parameter int N = 2
) (
	input  wire  [N-1:0] valid_in,
	output logic [N-1:0] ready_in,
	output logic         valid_out,
	input  wire          ready_out
);

	// joined token exists only when all inputs are valid
	assign valid_out = &valid_in;

	// input i is ready when downstream takes and every other input is valid
	for (genvar i = 0; i < N; i++) begin : g_ready
		logic [N-1:0] others;

		// force own bit high so only the other valids count
		assign others = valid_in | (N'(1) << i);
		assign ready_in[i] = ready_out & (&others);
	end

endmodule

`default_nettype wire

/* design/elastic_pkg.sv */
/*
 * elastic operator types
 * word, ALU opcode and request payload shared by all dataflow operators
 */
`default_nettype none

package elastic_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int DATA_WIDTH = 32;
	// low bits of operand b used as shift amount
	localparam int SHIFT_BITS = 5;

	typedef logic [DATA_WIDTH-1:0] word_t;

	// --------------------
	// ALU opcodes
	// --------------------
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_LSHR,
		ALU_ASHR,
		// compares give 0 or 1, zero extended
		ALU_EQ,
		ALU_NE,
		ALU_UGT,
		ALU_UGE,
		ALU_ULT,
		ALU_ULE,
		ALU_SGT,
		ALU_SGE,
		ALU_SLT,
		ALU_SLE
	} alu_op_t;

	// payload of the ALU first channel, opcode rides with operand a
	typedef struct packed {
		alu_op_t op;
		word_t   a;
	} alu_req_t;

endpackage

`default_nettype wire
